// File: design/bpu_config.svh
`ifndef BPU_CONFIG_SVH
`define BPU_CONFIG_SVH

// datapath widths
`define BPU_XLEN        32
`define BPU_HIST_LEN    12

// bimodal base table, 64 entries indexed by pc[7:2]
`define BPU_BIM_IDX_W   6

// tagged tables T0 and T1, 64 entries each
`define BPU_TAGE_IDX_W  6
`define BPU_TAGE_TAG_W  8

// direct-mapped BTB, 32 entries, index pc[6:2], tag pc[15:7]
`define BPU_BTB_IDX_W   5
`define BPU_BTB_TAG_W   9

// statistics register offsets
`define BPU_STAT_TOTAL   8'h00
`define BPU_STAT_CORRECT 8'h04
`define BPU_STAT_BIM     8'h08
`define BPU_STAT_T0      8'h0C
`define BPU_STAT_T1      8'h10

`endif

// File: design/rv_inst_pkg.sv
package rv_inst_pkg;

    // only the opcodes the fetch predictor cares about
    typedef enum logic [6:0] {
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111
    } rv_opcode_e;

    // conditional branch layout
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } rv_btype_t;

    // jal layout
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_jtype_t;

    // same fetched word, read as either format
    typedef union packed {
        rv_btype_t b;
        rv_jtype_t j;
    } rv_inst_u;

endpackage

// File: design/bpu_pkg.sv
`include "bpu_config.svh"

package bpu_pkg;

    // which table supplied the direction; 2'b11 is never used
    typedef enum logic [1:0] {
        PROV_BIMODAL = 2'd0,
        PROV_T0      = 2'd1,
        PROV_T1      = 2'd2
    } provider_e;

    // fetch-side prediction, history and provider echoed back by execute
    typedef struct packed {
        logic                     is_cf;
        logic                     taken;
        logic [`BPU_XLEN-1:0]     next_pc;
        logic [`BPU_HIST_LEN-1:0] history;
        provider_e                provider;
    } bpu_pred_t;

    // resolved branch from execute
    typedef struct packed {
        logic [`BPU_XLEN-1:0]     pc;
        logic                     taken;
        logic                     mispredict;
        logic [`BPU_XLEN-1:0]     target;
        logic [`BPU_HIST_LEN-1:0] history;
        provider_e                provider;
    } bpu_update_t;

    // one retired branch for the counters
    typedef struct packed {
        logic      valid;
        logic      correct;
        provider_e provider;
    } bpu_stat_evt_t;

    // direction lookup result
    typedef struct packed {
        logic                     taken;
        provider_e                provider;
        logic [`BPU_HIST_LEN-1:0] history;
    } dir_lookup_t;

endpackage

// File: design/tage_direction.sv
`timescale 1ns/1ps
`include "bpu_config.svh"

module tage_direction (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`BPU_XLEN-1:0]   lookup_pc_i,
    input  logic                   upd_valid_i,
    input  bpu_pkg::bpu_update_t   upd_i,
    output bpu_pkg::dir_lookup_t   dir_o,
    output bpu_pkg::bpu_stat_evt_t stat_evt_o
);
    import bpu_pkg::*;

    localparam int HIST_W = `BPU_HIST_LEN;
    localparam int IDX_W  = `BPU_TAGE_IDX_W;
    localparam int TAG_W  = `BPU_TAGE_TAG_W;
    localparam int BIM_N  = 1 << `BPU_BIM_IDX_W;
    localparam int TAGE_N = 1 << `BPU_TAGE_IDX_W;

    typedef struct packed {
        logic [IDX_W-1:0] idx;
        logic [TAG_W-1:0] tag;
    } tage_key_t;

    // T0 folds the short history, T1 the long one
    function automatic tage_key_t tage_key(input logic [`BPU_XLEN-1:0] pc,
                                           input logic [HIST_W-1:0] h,
                                           input logic long_h);
        tage_key_t k;
        k.idx = pc[IDX_W+1:2] ^ (long_h ? h[HIST_W-1 -: IDX_W] : h[IDX_W-1:0]);
        k.tag = pc[IDX_W+TAG_W+1 -: TAG_W] ^ (long_h ? h[HIST_W-1 -: TAG_W] : h[TAG_W-1:0]);
        return k;
    endfunction

    function automatic logic [1:0] sat_step(input logic [1:0] c, input logic up);
        if (up) begin
            return (c == 2'b11) ? c : c + 2'b01;
        end
        return (c == 2'b00) ? c : c - 2'b01;
    endfunction

    logic [HIST_W-1:0] ghist;
    logic [1:0]        bim_ctr [BIM_N];

    // index 0 is T0, index 1 is T1
    logic              tag_vld [2][TAGE_N];
    logic [TAG_W-1:0]  tag_tag [2][TAGE_N];
    logic [1:0]        tag_ctr [2][TAGE_N];

    tage_key_t lk_key [2];
    tage_key_t up_key [2];
    logic [1:0] lk_hit;
    logic       up_t1_hit;
    logic [`BPU_BIM_IDX_W-1:0] lk_bim_idx;
    logic [`BPU_BIM_IDX_W-1:0] up_bim_idx;
    logic [1:0] lk_ctr;
    logic       up_tbl;
    logic       alloc_tbl;

    assign lk_key[0] = tage_key(lookup_pc_i, ghist, 1'b0);
    assign lk_key[1] = tage_key(lookup_pc_i, ghist, 1'b1);
    // update uses the history captured at prediction time
    assign up_key[0] = tage_key(upd_i.pc, upd_i.history, 1'b0);
    assign up_key[1] = tage_key(upd_i.pc, upd_i.history, 1'b1);

    for (genvar t = 0; t < 2; t++) begin : g_match
        assign lk_hit[t] = tag_vld[t][lk_key[t].idx] &&
                           (tag_tag[t][lk_key[t].idx] == lk_key[t].tag);
    end

    assign up_t1_hit = tag_vld[1][up_key[1].idx] &&
                       (tag_tag[1][up_key[1].idx] == up_key[1].tag);

    assign lk_bim_idx = lookup_pc_i[`BPU_BIM_IDX_W+1:2];
    assign up_bim_idx = upd_i.pc[`BPU_BIM_IDX_W+1:2];

    // longest matching history wins
    always_comb begin
        if (lk_hit[1]) begin
            lk_ctr         = tag_ctr[1][lk_key[1].idx];
            dir_o.provider = PROV_T1;
        end else if (lk_hit[0]) begin
            lk_ctr         = tag_ctr[0][lk_key[0].idx];
            dir_o.provider = PROV_T0;
        end else begin
            lk_ctr         = bim_ctr[lk_bim_idx];
            dir_o.provider = PROV_BIMODAL;
        end
        dir_o.taken   = lk_ctr[1];
        dir_o.history = ghist;
    end

    assign up_tbl    = (upd_i.provider == PROV_T1);
    // T1 first, T0 when T1 already holds this branch
    assign alloc_tbl = !up_t1_hit;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ghist <= '0;
            for (int i = 0; i < BIM_N; i++) begin
                bim_ctr[i] <= 2'b01;
            end
            for (int i = 0; i < TAGE_N; i++) begin
                tag_vld[0][i] <= 1'b0;
                tag_vld[1][i] <= 1'b0;
            end
        end else if (upd_valid_i) begin
            // newest outcome in bit 0
            ghist <= {ghist[HIST_W-2:0], upd_i.taken};
            bim_ctr[up_bim_idx] <= sat_step(bim_ctr[up_bim_idx], upd_i.taken);
            if (upd_i.provider == PROV_BIMODAL && upd_i.mispredict) begin
                tag_vld[alloc_tbl][up_key[alloc_tbl].idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (upd_valid_i) begin
            if (upd_i.provider != PROV_BIMODAL) begin
                if (upd_i.mispredict) begin
                    tag_ctr[up_tbl][up_key[up_tbl].idx] <= upd_i.taken ? 2'b11 : 2'b00;
                end else begin
                    tag_ctr[up_tbl][up_key[up_tbl].idx] <=
                        sat_step(tag_ctr[up_tbl][up_key[up_tbl].idx], upd_i.taken);
                end
            end else if (upd_i.mispredict) begin
                // fresh entry starts weak in the resolved direction
                tag_tag[alloc_tbl][up_key[alloc_tbl].idx] <= up_key[alloc_tbl].tag;
                tag_ctr[alloc_tbl][up_key[alloc_tbl].idx] <= upd_i.taken ? 2'b10 : 2'b01;
            end
        end
    end

    assign stat_evt_o.valid    = upd_valid_i;
    assign stat_evt_o.correct  = !upd_i.mispredict;
    assign stat_evt_o.provider = upd_i.provider;

    // provider is echoed from fetch through execute
    a_upd_provider_legal: assert property (
        @(posedge clk) disable iff (rst)
        upd_valid_i |-> upd_i.provider != 2'b11
    );

endmodule

// File: design/branch_target_buffer.sv
`timescale 1ns/1ps
`include "bpu_config.svh"

module branch_target_buffer (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [`BPU_XLEN-1:0] lookup_pc_i,
    input  logic                 upd_valid_i,
    input  bpu_pkg::bpu_update_t upd_i,
    output logic                 btb_hit_o,
    output logic [`BPU_XLEN-1:0] btb_target_o
);
    localparam int IDX_W = `BPU_BTB_IDX_W;
    localparam int TAG_W = `BPU_BTB_TAG_W;
    localparam int BTB_N = 1 << `BPU_BTB_IDX_W;

    logic                 btb_vld [BTB_N];
    logic [TAG_W-1:0]     btb_tag [BTB_N];
    logic [`BPU_XLEN-1:0] btb_tgt [BTB_N];

    logic [IDX_W-1:0] lk_idx;
    logic [TAG_W-1:0] lk_tag;
    logic [IDX_W-1:0] up_idx;
    logic [TAG_W-1:0] up_tag;
    logic             fill;

    assign lk_idx = lookup_pc_i[IDX_W+1:2];
    assign lk_tag = lookup_pc_i[IDX_W+TAG_W+1 -: TAG_W];
    assign up_idx = upd_i.pc[IDX_W+1:2];
    assign up_tag = upd_i.pc[IDX_W+TAG_W+1 -: TAG_W];

    // only taken branches are worth a slot
    assign fill = upd_valid_i && upd_i.taken;

    assign btb_hit_o    = btb_vld[lk_idx] && (btb_tag[lk_idx] == lk_tag);
    assign btb_target_o = btb_tgt[lk_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < BTB_N; i++) begin
                btb_vld[i] <= 1'b0;
            end
        end else if (fill) begin
            btb_vld[up_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            btb_tag[up_idx] <= up_tag;
            btb_tgt[up_idx] <= upd_i.target;
        end
    end

    // execute only resolves to halfword boundaries
    a_target_aligned: assert property (
        @(posedge clk) disable iff (rst)
        fill |-> upd_i.target[0] == 1'b0
    );

endmodule

// File: design/fetch_predict.sv
`timescale 1ns/1ps
`include "bpu_config.svh"

module fetch_predict (
    input  logic [`BPU_XLEN-1:0] if_pc_i,
    input  logic [`BPU_XLEN-1:0] if_inst_i,
    input  bpu_pkg::dir_lookup_t dir_i,
    input  logic                 btb_hit_i,
    input  logic [`BPU_XLEN-1:0] btb_target_i,
    output bpu_pkg::bpu_pred_t   pred_o
);
    import rv_inst_pkg::*;
    import bpu_pkg::*;

    rv_inst_u             inst;
    logic                 is_jal;
    logic                 is_br;
    logic                 taken;
    logic [`BPU_XLEN-1:0] imm_j;
    logic [`BPU_XLEN-1:0] imm_b;

    assign inst   = if_inst_i;
    assign is_jal = (inst.j.opcode == OP_JAL);
    assign is_br  = (inst.b.opcode == OP_BRANCH);

    // sign-extended offsets, bit 0 always zero
    assign imm_j = {{(`BPU_XLEN-20){inst.j.imm20}}, inst.j.imm19_12, inst.j.imm11,
                    inst.j.imm10_1, 1'b0};
    assign imm_b = {{(`BPU_XLEN-12){inst.b.imm12}}, inst.b.imm11, inst.b.imm10_5,
                    inst.b.imm4_1, 1'b0};

    // jal is unconditional
    assign taken = is_jal || (is_br && dir_i.taken);

    always_comb begin
        pred_o.is_cf    = is_jal || is_br;
        pred_o.taken    = taken;
        pred_o.history  = dir_i.history;
        pred_o.provider = dir_i.provider;
        if (!taken) begin
            pred_o.next_pc = if_pc_i + `BPU_XLEN'd4;
        end else if (btb_hit_i) begin
            pred_o.next_pc = btb_target_i;
        end else if (is_jal) begin
            pred_o.next_pc = if_pc_i + imm_j;
        end else begin
            pred_o.next_pc = if_pc_i + imm_b;
        end
    end

endmodule

// File: design/bpu_stat_regs.sv
`timescale 1ns/1ps
`include "bpu_config.svh"

module bpu_stat_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  bpu_pkg::bpu_stat_evt_t stat_evt_i,
    input  logic [31:0]            s_axil_awaddr_i,
    input  logic                   s_axil_awvalid_i,
    output logic                   s_axil_awready_o,
    input  logic [31:0]            s_axil_wdata_i,
    input  logic                   s_axil_wvalid_i,
    output logic                   s_axil_wready_o,
    output logic [1:0]             s_axil_bresp_o,
    output logic                   s_axil_bvalid_o,
    input  logic                   s_axil_bready_i,
    input  logic [31:0]            s_axil_araddr_i,
    input  logic                   s_axil_arvalid_i,
    output logic                   s_axil_arready_o,
    output logic [31:0]            s_axil_rdata_o,
    output logic [1:0]             s_axil_rresp_o,
    output logic                   s_axil_rvalid_o,
    input  logic                   s_axil_rready_i
);
    import bpu_pkg::*;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic [31:0] cnt_total;
    logic [31:0] cnt_correct;
    logic [31:0] cnt_bim;
    logic [31:0] cnt_t0;
    logic [31:0] cnt_t1;
    logic        wr_hs;
    logic        rd_hs;

    // one write and one read in flight at most
    assign wr_hs            = s_axil_awvalid_i && s_axil_wvalid_i && !s_axil_bvalid_o;
    assign rd_hs            = s_axil_arvalid_i && !s_axil_rvalid_o;
    assign s_axil_awready_o = wr_hs;
    assign s_axil_wready_o  = wr_hs;
    assign s_axil_arready_o = rd_hs;
    assign s_axil_bresp_o   = RESP_OKAY;

    // any write clears the counters
    // a clear wins over a same-cycle event
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt_total   <= '0;
            cnt_correct <= '0;
            cnt_bim     <= '0;
            cnt_t0      <= '0;
            cnt_t1      <= '0;
        end else if (wr_hs) begin
            cnt_total   <= '0;
            cnt_correct <= '0;
            cnt_bim     <= '0;
            cnt_t0      <= '0;
            cnt_t1      <= '0;
        end else if (stat_evt_i.valid) begin
            cnt_total <= cnt_total + 32'd1;
            if (stat_evt_i.correct) begin
                cnt_correct <= cnt_correct + 32'd1;
                case (stat_evt_i.provider)
                    PROV_BIMODAL: cnt_bim <= cnt_bim + 32'd1;
                    PROV_T0:      cnt_t0  <= cnt_t0 + 32'd1;
                    PROV_T1:      cnt_t1  <= cnt_t1 + 32'd1;
                    default:      ;
                endcase
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s_axil_bvalid_o <= 1'b0;
            s_axil_rvalid_o <= 1'b0;
        end else begin
            if (wr_hs) begin
                s_axil_bvalid_o <= 1'b1;
            end else if (s_axil_bready_i) begin
                s_axil_bvalid_o <= 1'b0;
            end
            if (rd_hs) begin
                s_axil_rvalid_o <= 1'b1;
            end else if (s_axil_rready_i) begin
                s_axil_rvalid_o <= 1'b0;
            end
        end
    end

    // read data captured at the AR handshake
    always_ff @(posedge clk) begin
        if (rd_hs) begin
            s_axil_rresp_o <= RESP_OKAY;
            case (s_axil_araddr_i[7:0])
                `BPU_STAT_TOTAL:   s_axil_rdata_o <= cnt_total;
                `BPU_STAT_CORRECT: s_axil_rdata_o <= cnt_correct;
                `BPU_STAT_BIM:     s_axil_rdata_o <= cnt_bim;
                `BPU_STAT_T0:      s_axil_rdata_o <= cnt_t0;
                `BPU_STAT_T1:      s_axil_rdata_o <= cnt_t1;
                default: begin
                    s_axil_rdata_o <= '0;
                    s_axil_rresp_o <= RESP_SLVERR;
                end
            endcase
        end
    end

    a_rvalid_hold: assert property (
        @(posedge clk) disable iff (rst)
        s_axil_rvalid_o && !s_axil_rready_i |=> s_axil_rvalid_o && $stable(s_axil_rdata_o)
    );

endmodule

// File: design/branch_predictor.sv
`timescale 1ns/1ps
`include "bpu_config.svh"

module branch_predictor (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [`BPU_XLEN-1:0] if_pc_i,
    input  logic [`BPU_XLEN-1:0] if_inst_i,
    output bpu_pkg::bpu_pred_t   pred_o,
    input  logic                 upd_valid_i,
    input  bpu_pkg::bpu_update_t upd_i,
    input  logic [31:0]          s_axil_awaddr_i,
    input  logic                 s_axil_awvalid_i,
    output logic                 s_axil_awready_o,
    input  logic [31:0]          s_axil_wdata_i,
    input  logic                 s_axil_wvalid_i,
    output logic                 s_axil_wready_o,
    output logic [1:0]           s_axil_bresp_o,
    output logic                 s_axil_bvalid_o,
    input  logic                 s_axil_bready_i,
    input  logic [31:0]          s_axil_araddr_i,
    input  logic                 s_axil_arvalid_i,
    output logic                 s_axil_arready_o,
    output logic [31:0]          s_axil_rdata_o,
    output logic [1:0]           s_axil_rresp_o,
    output logic                 s_axil_rvalid_o,
    input  logic                 s_axil_rready_i
);
    import bpu_pkg::*;

    dir_lookup_t          dir;
    bpu_stat_evt_t        stat_evt;
    logic                 btb_hit;
    logic [`BPU_XLEN-1:0] btb_target;

    tage_direction u_tage (
        .clk         (clk),
        .rst         (rst),
        .lookup_pc_i (if_pc_i),
        .upd_valid_i (upd_valid_i),
        .upd_i       (upd_i),
        .dir_o       (dir),
        .stat_evt_o  (stat_evt)
    );

    branch_target_buffer u_btb (
        .clk          (clk),
        .rst          (rst),
        .lookup_pc_i  (if_pc_i),
        .upd_valid_i  (upd_valid_i),
        .upd_i        (upd_i),
        .btb_hit_o    (btb_hit),
        .btb_target_o (btb_target)
    );

    fetch_predict u_fetch (
        .if_pc_i      (if_pc_i),
        .if_inst_i    (if_inst_i),
        .dir_i        (dir),
        .btb_hit_i    (btb_hit),
        .btb_target_i (btb_target),
        .pred_o       (pred_o)
    );

    bpu_stat_regs u_stat (
        .clk              (clk),
        .rst              (rst),
        .stat_evt_i       (stat_evt),
        .s_axil_awaddr_i  (s_axil_awaddr_i),
        .s_axil_awvalid_i (s_axil_awvalid_i),
        .s_axil_awready_o (s_axil_awready_o),
        .s_axil_wdata_i   (s_axil_wdata_i),
        .s_axil_wvalid_i  (s_axil_wvalid_i),
        .s_axil_wready_o  (s_axil_wready_o),
        .s_axil_bresp_o   (s_axil_bresp_o),
        .s_axil_bvalid_o  (s_axil_bvalid_o),
        .s_axil_bready_i  (s_axil_bready_i),
        .s_axil_araddr_i  (s_axil_araddr_i),
        .s_axil_arvalid_i (s_axil_arvalid_i),
        .s_axil_arready_o (s_axil_arready_o),
        .s_axil_rdata_o   (s_axil_rdata_o),
        .s_axil_rresp_o   (s_axil_rresp_o),
        .s_axil_rvalid_o  (s_axil_rvalid_o),
        .s_axil_rready_i  (s_axil_rready_i)
    );

endmodule

// File: bench/bpu_tb.sv
`timescale 1ns/1ps
`include "bpu_config.svh"

module bpu_tb;
    import bpu_pkg::*;

    // about four times the cycles the directed tests need
    localparam int CYCLE_LIMIT = 2000;
    localparam logic [12:0] BR_IMM = 13'h010;
    localparam logic [31:0] NOP = 32'h00000013;

    logic clk = 1'b0;
    logic rst;
    logic [31:0] if_pc;
    logic [31:0] if_inst;
    bpu_pred_t pred;
    logic upd_valid;
    bpu_update_t upd;
    logic [31:0] awaddr;
    logic awvalid;
    logic awready;
    logic [31:0] wdata;
    logic wvalid;
    logic wready;
    logic [1:0] bresp;
    logic bvalid;
    logic bready;
    logic [31:0] araddr;
    logic arvalid;
    logic arready;
    logic [31:0] rdata;
    logic [1:0] rresp;
    logic rvalid;
    logic rready;

    integer seed = 32'hf1d2;
    int cycles = 0;

    // reference state of the direction predictor
    logic [1:0] m_bim [64];
    logic m_vld [2][64];
    logic [7:0] m_tag [2][64];
    logic [1:0] m_ctr [2][64];
    logic [`BPU_HIST_LEN-1:0] m_hist;

    // expected statistics
    logic [31:0] tally_total;
    logic [31:0] tally_correct;
    logic [31:0] tally_prov [4];

    branch_predictor uut (
        .clk              (clk),
        .rst              (rst),
        .if_pc_i          (if_pc),
        .if_inst_i        (if_inst),
        .pred_o           (pred),
        .upd_valid_i      (upd_valid),
        .upd_i            (upd),
        .s_axil_awaddr_i  (awaddr),
        .s_axil_awvalid_i (awvalid),
        .s_axil_awready_o (awready),
        .s_axil_wdata_i   (wdata),
        .s_axil_wvalid_i  (wvalid),
        .s_axil_wready_o  (wready),
        .s_axil_bresp_o   (bresp),
        .s_axil_bvalid_o  (bvalid),
        .s_axil_bready_i  (bready),
        .s_axil_araddr_i  (araddr),
        .s_axil_arvalid_i (arvalid),
        .s_axil_arready_o (arready),
        .s_axil_rdata_o   (rdata),
        .s_axil_rresp_o   (rresp),
        .s_axil_rvalid_o  (rvalid),
        .s_axil_rready_i  (rready)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("sim failed");
            $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $fatal(1);
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("sim failed");
            $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
            $fatal(1);
        end
    endtask

    // index and tag rules of the tagged tables
    // tbl 0 selects T0 and 1 selects T1
    function automatic logic [5:0] tage_index(input logic tbl, input logic [31:0] pc,
                                              input logic [11:0] h);
        return pc[7:2] ^ (tbl ? h[11:6] : h[5:0]);
    endfunction

    function automatic logic [7:0] tage_tag(input logic tbl, input logic [31:0] pc,
                                            input logic [11:0] h);
        return pc[15:8] ^ (tbl ? h[11:4] : h[7:0]);
    endfunction

    // pc that reaches the same T1 slot and tag under a newer history
    function automatic logic [31:0] alias_pc(input logic [31:0] pc, input logic [11:0] h_old,
                                             input logic [11:0] h_new);
        logic [31:0] a;
        a = pc;
        a[7:2] = tage_index(1'b1, pc, h_old) ^ h_new[11:6];
        a[15:8] = tage_tag(1'b1, pc, h_old) ^ h_new[11:4];
        return a;
    endfunction

    function automatic logic [1:0] counter_step(input logic [1:0] c, input logic up);
        if (up) begin
            return (c == 2'b11) ? c : c + 2'b01;
        end
        return (c == 2'b00) ? c : c - 2'b01;
    endfunction

    function automatic logic [31:0] random_pc();
        logic [31:0] r;
        r = $random(seed);
        return {r[31:2], 2'b00};
    endfunction

    function automatic logic [31:0] make_branch(input logic [12:0] imm);
        return {imm[12], imm[10:5], 5'd2, 5'd1, 3'b000, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] make_jal(input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, 7'b1101111};
    endfunction

    task automatic model_lookup(input logic [31:0] pc, output logic taken,
                                output provider_e prov);
        logic [5:0] i0;
        logic [5:0] i1;
        logic [1:0] ctr;
        i0 = tage_index(1'b0, pc, m_hist);
        i1 = tage_index(1'b1, pc, m_hist);
        if (m_vld[1][i1] && m_tag[1][i1] == tage_tag(1'b1, pc, m_hist)) begin
            prov = PROV_T1;
            ctr = m_ctr[1][i1];
        end else if (m_vld[0][i0] && m_tag[0][i0] == tage_tag(1'b0, pc, m_hist)) begin
            prov = PROV_T0;
            ctr = m_ctr[0][i0];
        end else begin
            prov = PROV_BIMODAL;
            ctr = m_bim[pc[7:2]];
        end
        taken = ctr[1];
    endtask

    task automatic model_update(input logic [31:0] pc, input logic taken, input logic mis,
                                input provider_e prov);
        logic t;
        logic [5:0] i;
        m_bim[pc[7:2]] = counter_step(m_bim[pc[7:2]], taken);
        if (prov != PROV_BIMODAL) begin
            t = (prov == PROV_T1);
            i = tage_index(t, pc, m_hist);
            m_ctr[t][i] = mis ? {taken, taken} : counter_step(m_ctr[t][i], taken);
        end else if (mis) begin
            // T0 only when T1 already holds this branch
            i = tage_index(1'b1, pc, m_hist);
            t = !(m_vld[1][i] && m_tag[1][i] == tage_tag(1'b1, pc, m_hist));
            i = tage_index(t, pc, m_hist);
            m_vld[t][i] = 1'b1;
            m_tag[t][i] = tage_tag(t, pc, m_hist);
            m_ctr[t][i] = taken ? 2'b10 : 2'b01;
        end
        m_hist = {m_hist[10:0], taken};
    endtask

    task automatic fetch(input logic [31:0] pc, input logic [31:0] inst);
        @(posedge clk);
        if_pc <= pc;
        if_inst <= inst;
        @(negedge clk);
    endtask

    // predict a branch, then resolve it from execute with the echoed state
    task automatic retire_branch(input logic [31:0] pc, input logic taken,
                                 input logic [31:0] target);
        logic guess;
        provider_e prov;
        logic mis;
        model_lookup(pc, guess, prov);
        fetch(pc, make_branch(BR_IMM));
        check_value("pred_o.taken", 32'(pred.taken), 32'(guess));
        check_value("pred_o.provider", 32'(pred.provider), 32'(prov));
        check_value("pred_o.history", 32'(pred.history), 32'(m_hist));
        mis = (guess != taken);
        @(posedge clk);
        upd_valid <= 1'b1;
        upd <= '{pc: pc, taken: taken, mispredict: mis, target: target,
                 history: m_hist, provider: prov};
        @(posedge clk);
        upd_valid <= 1'b0;
        tally_total = tally_total + 32'd1;
        if (!mis) begin
            tally_correct = tally_correct + 32'd1;
            tally_prov[prov] = tally_prov[prov] + 32'd1;
        end
        model_update(pc, taken, mis, prov);
    endtask

    task automatic axi_read_expect(input logic [31:0] addr, input logic [31:0] exp_data,
                                   input logic [1:0] exp_resp);
        @(posedge clk);
        araddr <= addr;
        arvalid <= 1'b1;
        do @(negedge clk); while (!arready);
        @(posedge clk);
        arvalid <= 1'b0;
        do @(negedge clk); while (!rvalid);
        check_value("s_axil_rdata_o", rdata, exp_data);
        check_value("s_axil_rresp_o", 32'(rresp), 32'(exp_resp));
        @(posedge clk);
        rready <= 1'b1;
        @(posedge clk);
        rready <= 1'b0;
    endtask

    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk);
        awaddr <= addr;
        wdata <= data;
        awvalid <= 1'b1;
        wvalid <= 1'b1;
        do @(negedge clk); while (!awready);
        // address and data are taken in the same cycle
        check_value("s_axil_wready_o", 32'(wready), 32'd1);
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid <= 1'b0;
        bready <= 1'b1;
        do @(negedge clk); while (!bvalid);
        check_value("s_axil_bresp_o", 32'(bresp), 32'd0);
        @(posedge clk);
        bready <= 1'b0;
    endtask

    task automatic test_reset_state();
        logic [31:0] pc;
        pc = random_pc();
        fetch(pc, NOP);
        check_value("pred_o.is_cf", 32'(pred.is_cf), 32'd0);
        check_value("pred_o.next_pc", pred.next_pc, pc + 32'd4);
        fetch(pc, make_branch(BR_IMM));
        check_value("pred_o.taken", 32'(pred.taken), 32'd0);
        check_value("pred_o.provider", 32'(pred.provider), 32'(PROV_BIMODAL));
        check_value("pred_o.history", 32'(pred.history), 32'd0);
        check_value("pred_o.next_pc", pred.next_pc, pc + 32'd4);
    endtask

    task automatic test_jal_btb_miss();
        logic [31:0] pc;
        logic [20:0] imm;
        pc = random_pc();
        imm = 21'h1ffc00;
        fetch(pc, make_jal(imm));
        check_value("pred_o.is_cf", 32'(pred.is_cf), 32'd1);
        check_value("pred_o.taken", 32'(pred.taken), 32'd1);
        check_value("pred_o.next_pc", pred.next_pc, pc + {{11{imm[20]}}, imm});
    endtask

    task automatic test_bimodal_btb();
        logic [31:0] pc;
        logic [31:0] tgt;
        pc = random_pc();
        // differs from the immediate target pc + 16
        tgt = pc + 32'h100;
        retire_branch(pc, 1'b1, tgt);
        retire_branch(pc, 1'b1, tgt);
        fetch(pc, make_branch(BR_IMM));
        check_value("pred_o.taken", 32'(pred.taken), 32'd1);
        check_value("pred_o.next_pc", pred.next_pc, tgt);
    endtask

    task automatic test_history_shift();
        logic [31:0] r;
        for (int n = 0; n < 100; n++) begin
            r = $random(seed);
            retire_branch(random_pc(), r[0], random_pc());
        end
        fetch(random_pc(), make_branch(BR_IMM));
        check_value("pred_o.history", 32'(pred.history), 32'(m_hist));
    endtask

    task automatic test_t1_alloc();
        logic [31:0] pc;
        logic [11:0] h_prev;
        logic guess;
        logic actual;
        provider_e prov;
        do begin
            pc = random_pc();
            model_lookup(pc, guess, prov);
        end while (prov != PROV_BIMODAL);
        actual = !guess;
        h_prev = m_hist;
        retire_branch(pc, actual, pc + 32'h40);
        pc = alias_pc(pc, h_prev, m_hist);
        fetch(pc, make_branch(BR_IMM));
        check_value("pred_o.provider", 32'(pred.provider), 32'(PROV_T1));
        check_value("pred_o.taken", 32'(pred.taken), 32'(actual));
        // correct outcome strengthens, a wrong one flips to strong
        h_prev = m_hist;
        retire_branch(pc, actual, pc + 32'h40);
        pc = alias_pc(pc, h_prev, m_hist);
        h_prev = m_hist;
        retire_branch(pc, !actual, pc + 32'h40);
        pc = alias_pc(pc, h_prev, m_hist);
        fetch(pc, make_branch(BR_IMM));
        check_value("pred_o.provider", 32'(pred.provider), 32'(PROV_T1));
        check_value("pred_o.taken", 32'(pred.taken), 32'(!actual));
    endtask

    task automatic test_stat_port();
        axi_read_expect(32'(`BPU_STAT_TOTAL), tally_total, 2'b00);
        axi_read_expect(32'(`BPU_STAT_CORRECT), tally_correct, 2'b00);
        axi_read_expect(32'(`BPU_STAT_BIM), tally_prov[PROV_BIMODAL], 2'b00);
        axi_read_expect(32'(`BPU_STAT_T0), tally_prov[PROV_T0], 2'b00);
        axi_read_expect(32'(`BPU_STAT_T1), tally_prov[PROV_T1], 2'b00);
        axi_read_expect(32'h14, 32'd0, 2'b10);
        axi_write(32'(`BPU_STAT_TOTAL), 32'hffffffff);
        axi_read_expect(32'(`BPU_STAT_TOTAL), 32'd0, 2'b00);
        axi_read_expect(32'(`BPU_STAT_CORRECT), 32'd0, 2'b00);
        axi_read_expect(32'(`BPU_STAT_BIM), 32'd0, 2'b00);
        axi_read_expect(32'(`BPU_STAT_T0), 32'd0, 2'b00);
        axi_read_expect(32'(`BPU_STAT_T1), 32'd0, 2'b00);
    endtask

    initial begin
        rst = 1'b1;
        if_pc = '0;
        if_inst = NOP;
        upd_valid = 1'b0;
        upd = '0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        m_hist = '0;
        tally_total = '0;
        tally_correct = '0;
        for (int i = 0; i < 4; i++) begin
            tally_prov[i] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            m_bim[i] = 2'b01;
            m_vld[0][i] = 1'b0;
            m_vld[1][i] = 1'b0;
        end
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        test_reset_state();
        test_jal_btb_miss();
        test_bimodal_btb();
        test_history_shift();
        test_t1_alloc();
        test_stat_port();
        $display("sim passed");
        $finish;
    end

endmodule

// File: tb.f
+incdir+design
design/rv_inst_pkg.sv
design/bpu_pkg.sv
design/tage_direction.sv
design/branch_target_buffer.sv
design/fetch_predict.sv
design/bpu_stat_regs.sv
design/branch_predictor.sv
bench/bpu_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the branch predictor testbench with Verilator and run it
# the exit status is the simulator's, nonzero after a $fatal
verilator --binary --timing --assert -f tb.f --top-module bpu_tb -o bpu_sim &&
    ./obj_dir/bpu_sim ||
    exit 1
